// ==== armRegFile_params.svh ====
// register file sizing macros
// widths, register count and program counter settings for the ARM-style core

`ifndef ARM_REG_FILE_PARAMS_SVH
`define ARM_REG_FILE_PARAMS_SVH

// data path word width
`define RF_DATA_W 32

// number of general purpose registers, PC included
`define RF_NUM_REGS 16

// bits needed to name one register
`define RF_IDX_W 4

// r15 doubles as the program counter
`define RF_PC_IDX 15

// byte step per instruction
`define RF_PC_STEP 4

// condition code width, NZCV
`define CC_W 4

`endif

// ==== datapathPkg.sv ====
// datapath types for the register file
// data words, register numbers and one-hot write selects

`default_nettype none

`include "armRegFile_params.svh"

package datapathPkg;

  // one data word as read or written through a port
  typedef logic [`RF_DATA_W-1:0] word_t;

  // register number, r0 to r15
  typedef logic [`RF_IDX_W-1:0] regIdx_t;

  // decoded write select
  // bit n set means register n loads this cycle
  typedef logic [`RF_NUM_REGS-1:0] regMask_t;

endpackage

`default_nettype wire

// ==== condPkg.sv ====
// condition code types
// flag vector and the bit position of each flag

`default_nettype none

`include "armRegFile_params.svh"

package condPkg;

  // NZCV, negative in the top bit
  typedef logic [`CC_W-1:0] ccFlags_t;

  // bit positions inside ccFlags_t
  localparam int unsigned CC_N = 3;
  localparam int unsigned CC_Z = 2;
  localparam int unsigned CC_C = 1;
  localparam int unsigned CC_V = 0;

endpackage

`default_nettype wire

// ==== regReadIf.sv ====
// read port bundle for the register file
// three addresses out, three data words back, no handshake

`default_nettype none

interface regReadIf
  import datapathPkg::*;
();

  // one address per read port
  regIdx_t addrA;
  regIdx_t addrB;
  regIdx_t addrC;

  // data follows the address in the same cycle
  word_t dataA;
  word_t dataB;
  word_t dataC;

  // side that picks the registers
  modport requester (output addrA, addrB, addrC, input dataA, dataB, dataC);

  // storage side
  modport responder (input addrA, addrB, addrC, output dataA, dataB, dataC);

endinterface

`default_nettype wire

// ==== pcUnit.sv ====
// program counter next-value logic
// picks an explicit r15 write, the stepped PC or the held PC

`default_nettype none

`include "armRegFile_params.svh"

module pcUnit
  import datapathPkg::*;
(
  // currently stored PC, straight from r15
  input  word_t   pcCur,
  // advance by one instruction
  input  logic    pcStep,
  // shared write port
  input  logic    wrEn,
  input  regIdx_t wrIdx,
  input  word_t   wrData,
  // value r15 takes on the next edge
  output word_t   pcNext
);

  // write port aimed at r15
  logic  pcWrite;
  // stored PC plus one instruction
  word_t pcInc;

  // only place that asks whether a write hits the PC
  assign pcWrite = wrEn && (wrIdx == regIdx_t'(`RF_PC_IDX));

  // wraps past the top of the address space
  assign pcInc = pcCur + word_t'(`RF_PC_STEP);

  // explicit write wins over the step
  // so a branch target is never skipped by four
  always_comb
  begin
    if (pcWrite)
    begin
      pcNext = wrData;
    end
    else if (pcStep)
    begin
      pcNext = pcInc;
    end
    else
    begin
      // hold
      pcNext = pcCur;
    end
  end

endmodule

`default_nettype wire

// ==== regArray.sv ====
// sixteen-entry register storage
// one decoded write port, r15 loaded from the PC unit, three async read muxes

`default_nettype none

`include "armRegFile_params.svh"

module regArray
  import datapathPkg::*;
(
  input  logic    clk,
  input  logic    clr,
  // write port for r0..r14
  input  logic    wrEn,
  input  regIdx_t wrIdx,
  input  word_t   wrData,
  // next r15 value from the PC unit
  input  word_t   pcNext,
  // stored r15
  output word_t   pcCur,
  // three read ports
  regReadIf.responder rd
);

  // register contents
  word_t    regs [`RF_NUM_REGS];
  // one-hot write select
  regMask_t wrMask;

  // write decode
  always_comb
  begin
    wrMask = '0;
    if (wrEn)
    begin
      wrMask[wrIdx] = 1'b1;
    end
  end

  // storage update
  // r15 follows pcNext every edge, the PC unit already folded in any write
  always_ff @(posedge clk or negedge clr)
  begin
    if (!clr)
    begin
      for (int i = 0; i < `RF_NUM_REGS; i++)
        regs[i] <= '0;
    end
    else
    begin
      for (int i = 0; i < `RF_PC_IDX; i++)
      begin
        if (wrMask[i])
          regs[i] <= wrData;
      end
      regs[`RF_PC_IDX] <= pcNext;
    end
  end

  assign pcCur = regs[`RF_PC_IDX];

  // one 16-to-1 select, shared by all three ports
  function automatic word_t readSel(input regIdx_t idx);
    case (idx)
      4'd0:    readSel = regs[0];
      4'd1:    readSel = regs[1];
      4'd2:    readSel = regs[2];
      4'd3:    readSel = regs[3];
      4'd4:    readSel = regs[4];
      4'd5:    readSel = regs[5];
      4'd6:    readSel = regs[6];
      4'd7:    readSel = regs[7];
      4'd8:    readSel = regs[8];
      4'd9:    readSel = regs[9];
      4'd10:   readSel = regs[10];
      4'd11:   readSel = regs[11];
      4'd12:   readSel = regs[12];
      4'd13:   readSel = regs[13];
      4'd14:   readSel = regs[14];
      default: readSel = regs[15];
    endcase
  endfunction

  // reads see stored values only, no write bypass
  always_comb
  begin
    rd.dataA = readSel(rd.addrA);
  end

  always_comb
  begin
    rd.dataB = readSel(rd.addrB);
  end

  always_comb
  begin
    rd.dataC = readSel(rd.addrC);
  end

  // at most one register written per edge, whatever the write port does
  aWrMaskOneHot: assert property (@(posedge clk) disable iff (!clr) $onehot0(wrMask))
    else $error("regArray: write mask %b selects more than one register", wrMask);

endmodule

`default_nettype wire

// ==== flagReg.sv ====
// condition code register
// NZCV flags, loaded on demand beside the datapath

`default_nettype none

module flagReg
  import condPkg::*;
(
  input  logic     clk,
  input  logic     clr,
  // take new flags on this edge
  input  logic     flagLoad,
  input  ccFlags_t flagsIn,
  // stored flags
  output ccFlags_t flagsOut
);

  // flags hold unless an instruction sets them
  always_ff @(posedge clk or negedge clr)
  begin
    if (!clr)
    begin
      flagsOut <= '0;
    end
    else if (flagLoad)
    begin
      flagsOut <= flagsIn;
    end
  end

  // no load, no change in the following cycle
  aFlagsHold: assert property (
    @(posedge clk) disable iff (!clr) !flagLoad |=> $stable(flagsOut)
  )
    else $error("flagReg: flags changed without a load");

endmodule

`default_nettype wire

// ==== armRegFile.sv ====
// ARM-style register file top level
// sixteen 32-bit registers with r15 as PC, three read ports, NZCV flags

`default_nettype none

module armRegFile
  import datapathPkg::*;
  import condPkg::*;
(
  input  logic     clk,
  input  logic     clr,
  // write port
  input  logic     wrEn,
  input  regIdx_t  wrIdx,
  input  word_t    wrData,
  // PC advance
  input  logic     pcStep,
  // read addresses
  input  regIdx_t  addrA,
  input  regIdx_t  addrB,
  input  regIdx_t  addrC,
  // flag update
  input  logic     flagLoad,
  input  ccFlags_t flagsIn,
  // read data
  output word_t    dataA,
  output word_t    dataB,
  output word_t    dataC,
  // stored PC
  output word_t    pcOut,
  output ccFlags_t flagsOut
);

  // stored and next PC between array and PC unit
  word_t pcCur;
  word_t pcNext;

  // read bundle, top acts as requester
  regReadIf rdBus ();

  assign rdBus.addrA = addrA;
  assign rdBus.addrB = addrB;
  assign rdBus.addrC = addrC;

  assign dataA = rdBus.dataA;
  assign dataB = rdBus.dataB;
  assign dataC = rdBus.dataC;

  assign pcOut = pcCur;

  // storage and read muxes
  regArray uArray (
    .clk    (clk),
    .clr    (clr),
    .wrEn   (wrEn),
    .wrIdx  (wrIdx),
    .wrData (wrData),
    .pcNext (pcNext),
    .pcCur  (pcCur),
    .rd     (rdBus.responder)
  );

  // r15 next value
  pcUnit uPc (
    .pcCur  (pcCur),
    .pcStep (pcStep),
    .wrEn   (wrEn),
    .wrIdx  (wrIdx),
    .wrData (wrData),
    .pcNext (pcNext)
  );

  // status flags
  flagReg uFlags (
    .clk      (clk),
    .clr      (clr),
    .flagLoad (flagLoad),
    .flagsIn  (flagsIn),
    .flagsOut (flagsOut)
  );

endmodule

`default_nettype wire

// ==== regFileModel.svh ====
// reference model for the register file testbench
// expected register and flag image, stepped once per clock edge, plus the LCG

`ifndef REG_FILE_MODEL_SVH
`define REG_FILE_MODEL_SVH

// expected register contents, r15 is the PC
word_t       mRegs [`RF_NUM_REGS];
// expected NZCV
ccFlags_t    mFlags;
// random generator state
logic [31:0] rngState;

// plain 32-bit LCG step
function automatic logic [31:0] lcgNext(input logic [31:0] s);
  return s * 32'd1664525 + 32'd1013904223;
endfunction

// advance the generator and hand back the new value
function automatic logic [31:0] nextRand();
  rngState = lcgNext(rngState);
  return rngState;
endfunction

// everything reads zero after clear
task automatic modelClear();
  for (int i = 0; i < `RF_NUM_REGS; i++)
  begin
    mRegs[i] = '0;
  end
  mFlags = '0;
endtask

// one rising edge with the given inputs
task automatic modelEdge(
  input logic     we,
  input regIdx_t  idx,
  input word_t    data,
  input logic     step,
  input logic     fl,
  input ccFlags_t fin
);
  logic pcHit;
  pcHit = we && (idx == `RF_PC_IDX);
  // ordinary write, r15 included
  if (we)
  begin
    mRegs[idx] = data;
  end
  // step only when the write missed the PC
  if (step && !pcHit)
  begin
    mRegs[`RF_PC_IDX] = mRegs[`RF_PC_IDX] + `RF_PC_STEP;
  end
  // flags load on demand
  if (fl)
  begin
    mFlags = fin;
  end
endtask

`endif

// ==== regFileTb.sv ====
// testbench for the ARM-style register file
// directed reset and PC wrap checks, then random traffic against a model

`default_nettype none

`include "armRegFile_params.svh"

module regFileTb
  import datapathPkg::*;
  import condPkg::*;
();

  localparam int          RESET_CYCLES   = 5;
  localparam int          NUM_CYCLES     = 2000;
  // random run plus room for reset, sweep and wrap phases
  localparam int          TIMEOUT_CYCLES = NUM_CYCLES + NUM_CYCLES / 20;
  localparam logic [31:0] SEED           = 32'he715_3c3c;

  logic     clk;
  logic     clr;
  logic     wrEn;
  regIdx_t  wrIdx;
  word_t    wrData;
  logic     pcStep;
  regIdx_t  addrA;
  regIdx_t  addrB;
  regIdx_t  addrC;
  logic     flagLoad;
  ccFlags_t flagsIn;
  word_t    dataA;
  word_t    dataB;
  word_t    dataC;
  word_t    pcOut;
  ccFlags_t flagsOut;

  int       cycleCount;

  `include "regFileModel.svh"

  armRegFile dut (
    .clk      (clk),
    .clr      (clr),
    .wrEn     (wrEn),
    .wrIdx    (wrIdx),
    .wrData   (wrData),
    .pcStep   (pcStep),
    .addrA    (addrA),
    .addrB    (addrB),
    .addrC    (addrC),
    .flagLoad (flagLoad),
    .flagsIn  (flagsIn),
    .dataA    (dataA),
    .dataB    (dataB),
    .dataC    (dataC),
    .pcOut    (pcOut),
    .flagsOut (flagsOut)
  );

  // period 4
  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // run limit
  initial
  begin
    cycleCount = 0;
    while (cycleCount < TIMEOUT_CYCLES)
    begin
      @(posedge clk);
      cycleCount++;
    end
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TEST FAILED");
    $fatal(1, "timeout");
  end

  // compare one value, stop at the first mismatch
  task automatic checkValue(input string sig, input word_t expVal, input word_t actVal);
    assert (actVal === expVal)
    else
    begin
      $display("Fail time=%0t signal=%s expected=%h actual=%h", $time, sig, expVal, actVal);
      $display("TEST FAILED");
      $fatal(1, "mismatch on %s", sig);
    end
  endtask

  // all outputs against the model, just before the edge
  task automatic checkOutputs();
    checkValue("dataA", mRegs[addrA], dataA);
    checkValue("dataB", mRegs[addrB], dataB);
    checkValue("dataC", mRegs[addrC], dataC);
    checkValue("pcOut", mRegs[`RF_PC_IDX], pcOut);
    checkValue("flagsOut", word_t'(mFlags), word_t'(flagsOut));
  endtask

  // drive at edge plus 1, check at edge plus 3, then step the model on the edge
  task automatic runCycle(
    input logic     we,
    input regIdx_t  idx,
    input word_t    data,
    input logic     step,
    input regIdx_t  aA,
    input regIdx_t  aB,
    input regIdx_t  aC,
    input logic     fl,
    input ccFlags_t fin
  );
    wrEn     = we;
    wrIdx    = idx;
    wrData   = data;
    pcStep   = step;
    addrA    = aA;
    addrB    = aB;
    addrC    = aC;
    flagLoad = fl;
    flagsIn  = fin;
    #2;
    checkOutputs();
    @(posedge clk);
    modelEdge(we, idx, data, step, fl, fin);
    #1;
  endtask

  initial
  begin
    logic [31:0] ctl;
    logic [31:0] adr;
    word_t       data;
    regIdx_t     idx;
    regIdx_t     aA;

    clr        = 1'b0;
    wrEn       = 1'b0;
    wrIdx      = '0;
    wrData     = '0;
    pcStep     = 1'b0;
    addrA      = '0;
    addrB      = '0;
    addrC      = '0;
    flagLoad   = 1'b0;
    flagsIn    = '0;
    rngState   = SEED;
    modelClear();

    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    clr = 1'b1;

    // every address reads zero after reset
    for (int i = 0; i < `RF_NUM_REGS; i++)
    begin
      runCycle(1'b0, '0, '0, 1'b0, regIdx_t'(i), regIdx_t'(15 - i), regIdx_t'(i), 1'b0, '0);
    end

    // PC write beats the step, then wrap past the top
    runCycle(1'b1, 4'd15, 32'hffff_fff8, 1'b1, 4'd15, 4'd0, 4'd15, 1'b1, 4'b1010);
    repeat (4)
    begin
      runCycle(1'b0, '0, '0, 1'b1, 4'd15, 4'd15, 4'd0, 1'b0, 4'b0101);
    end

    // random traffic
    for (int n = 0; n < NUM_CYCLES; n++)
    begin
      ctl  = nextRand();
      data = nextRand();
      adr  = nextRand();
      idx  = ctl[27:24];
      aA   = adr[31:28];
      // often read back the register being written, same cycle
      if (adr[19:18] == 2'b00)
      begin
        aA = idx;
      end
      runCycle(ctl[31], idx, data, ctl[23:22] != 2'b00, aA, adr[27:24], adr[23:20],
               ctl[21], ctl[20:17]);
    end

    // any mismatch has already stopped the run
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== armRegFile.f ====
+incdir+.
datapathPkg.sv
condPkg.sv
regReadIf.sv
pcUnit.sv
regArray.sv
flagReg.sv
armRegFile.sv
regFileTb.sv

// ==== Bender.yml ====
package:
  name: armRegFile

export_include_dirs:
  - .

sources:
  - datapathPkg.sv
  - condPkg.sv
  - regReadIf.sv
  - pcUnit.sv
  - regArray.sv
  - flagReg.sv
  - armRegFile.sv
  - target: test
    files:
      - regFileTb.sv
